// File: tb.f
+incdir+.
bus_pkg.sv
ram_pkg.sv
bus_request_stage.sv
half_word_sequencer.sv
sram_16.sv
mem_16_to_32_top.sv
tb_mem_16_to_32.sv

// File: Makefile
# Verilator build and run of the memory bridge testbench

TOP       ?= tb_mem_16_to_32
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation and search $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: TOP FILELIST OBJ_DIR LOG VERILATOR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@rm -f $(LOG)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_mem_16_to_32.sv
// Testbench for the 32-bit to 16-bit memory bridge with LFSR stimulus and a word model
`timescale 1ns/1ps

`include "mem_consts.svh"

module tb_mem_16_to_32;

	localparam int N_DIRECTED = 11;
	localparam int N_RAND     = 400;
	localparam int N_TXN      = N_DIRECTED + N_RAND;
	localparam int TIMEOUT_NS = N_TXN * 4 * (`RAM_WAIT + 10) * 4;

	localparam logic [31:0] WIN_BASE = 32'h0001_3a00;	// Bits 7:0 clear, 64-word window

	logic        i_clock;
	logic        i_rst;
	logic        i_enable;
	logic        i_rw;
	logic [31:0] i_address;
	logic [31:0] i_wdata;
	logic [31:0] o_rdata;
	logic        o_ready;

	logic [31:0] lfsr;
	logic [31:0] model [64];	// Indexed by address bits 7:2
	int          error_count;
	int          read_count;
	int          write_count;
	int          abort_count;
	logic        rewrite_pending;	// Word left half-written by an abort
	logic [5:0]  rewrite_idx;

	mem_16_to_32_top DUT (
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_enable  (i_enable),
		.i_rw      (i_rw),
		.i_address (i_address),
		.i_wdata   (i_wdata),
		.o_rdata   (o_rdata),
		.o_ready   (o_ready)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};	// One step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [31:0] word_addr(input logic [5:0] idx, input logic [1:0] low);
		return WIN_BASE | {24'h0, idx, low};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		error_count++;
		$display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_ready(input logic expected);
		assert (o_ready === expected)
		else report_mismatch("o_ready", {31'b0, expected}, {31'b0, o_ready});
	endtask

	task automatic check_rdata(input logic [31:0] expected);
		assert (o_rdata === expected)
		else report_mismatch("o_rdata", expected, o_rdata);
	endtask

	// Idle cycles with i_enable low
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge i_clock);
			check_ready(1'b0);
		end
	endtask

	// One access on the level protocol, abort_after of zero runs it to o_ready
	task automatic run_access(input logic rw, input logic [31:0] addr, input logic [31:0] wdata,
			input int abort_after, input int hold);
		logic [5:0] idx;
		logic       seen;
		logic       aborted;
		int         cycles;

		idx     = addr[7:2];
		seen    = 1'b0;
		aborted = 1'b0;
		cycles  = 0;

		@(posedge i_clock);
		i_enable  <= 1'b1;
		i_rw      <= rw;
		i_address <= addr;
		i_wdata   <= wdata;

		while (!seen && !aborted) begin
			@(negedge i_clock);
			if (o_ready) begin
				seen = 1'b1;
			end else begin
				cycles++;
				if (abort_after > 0 && cycles >= abort_after) begin
					aborted = 1'b1;
				end
			end
		end

		if (seen) begin
			if (rw) begin
				model[idx] = wdata;
				write_count++;
				if (rewrite_pending && idx == rewrite_idx) begin
					rewrite_pending = 1'b0;
				end
			end else begin
				check_rdata(model[idx]);
				read_count++;
			end
			repeat (hold) begin
				@(negedge i_clock);
				check_ready(1'b1);	// Held while i_enable stays high
				if (!rw) begin
					check_rdata(model[idx]);
				end
			end
		end else begin
			abort_count++;
			if (rw) begin
				rewrite_pending = 1'b1;
				rewrite_idx     = idx;
			end
		end

		@(posedge i_clock);
		i_enable <= 1'b0;
		@(negedge i_clock);
		if (seen) begin
			check_ready(1'b1);	// Low level not yet sampled
		end
		@(negedge i_clock);
		check_ready(1'b0);
	endtask

	task automatic random_access();
		logic [31:0] r_rw;
		logic [31:0] r_idx;
		logic [31:0] r_low;
		logic [31:0] r_data;
		logic [31:0] r_abort;
		logic [31:0] r_delay;
		logic [31:0] r_hold;
		logic [31:0] r_gap;
		logic        rw;
		logic [5:0]  idx;
		int          abort_after;

		draw_bits(1, r_rw);
		draw_bits(6, r_idx);
		draw_bits(2, r_low);
		draw_bits(32, r_data);
		draw_bits(4, r_abort);
		draw_bits(3, r_delay);
		draw_bits(2, r_hold);
		draw_bits(1, r_gap);

		rw          = r_rw[0];
		idx         = r_idx[5:0];
		abort_after = (r_abort[3:0] == 4'd0) ? int'(r_delay[2:0]) + 1 : 0;	// About 1 in 16

		// A half-written word gets a full write before anything else
		if (rewrite_pending) begin
			rw          = 1'b1;
			idx         = rewrite_idx;
			abort_after = 0;
		end

		run_access(rw, word_addr(idx, r_low[1:0]), r_data, abort_after, int'(r_hold[1:0]));
		idle_cycles(int'(r_gap[0]));
	endtask

	initial begin
		i_rst           = 1'b1;
		i_enable        = 1'b0;
		i_rw            = 1'b0;
		i_address       = '0;
		i_wdata         = '0;
		lfsr            = 32'h4a81154c;
		error_count     = 0;
		read_count      = 0;
		write_count     = 0;
		abort_count     = 0;
		rewrite_pending = 1'b0;
		rewrite_idx     = '0;
		for (int i = 0; i < 64; i++) begin
			model[i] = '0;
		end

		repeat (3) @(posedge i_clock);
		i_rst <= 1'b0;
		idle_cycles(4);

		// Untouched word reads as zero
		run_access(1'b0, word_addr(6'd40, 2'd0), 32'h0, 0, 0);

		// Round trip with distinct halves
		run_access(1'b1, word_addr(6'd5, 2'd0), 32'hbeef_1234, 0, 0);
		idle_cycles(1);
		run_access(1'b0, word_addr(6'd5, 2'd0), 32'h0, 0, 2);

		// Write and read through different low address bits
		run_access(1'b1, word_addr(6'd9, 2'd1), 32'h5a5a_c3c3, 0, 0);
		run_access(1'b0, word_addr(6'd9, 2'd3), 32'h0, 0, 3);
		run_access(1'b0, word_addr(6'd9, 2'd2), 32'h0, 0, 0);

		// Aborted read, then a full one
		run_access(1'b0, word_addr(6'd5, 2'd1), 32'h0, 4, 0);
		run_access(1'b0, word_addr(6'd5, 2'd0), 32'h0, 0, 1);

		// Aborted write repaired by a full write
		run_access(1'b1, word_addr(6'd9, 2'd0), 32'h1111_2222, 6, 0);
		run_access(1'b1, word_addr(6'd9, 2'd2), 32'h3333_4444, 0, 0);
		run_access(1'b0, word_addr(6'd9, 2'd1), 32'h0, 0, 0);

		for (int n = 0; n < N_RAND; n++) begin
			random_access();
		end
		idle_cycles(2);

		if (error_count == 0) begin
			$display("%0d reads, %0d writes, %0d aborts", read_count, write_count, abort_count);
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: o_ready never came within %0d ns", TIMEOUT_NS);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: mem_16_to_32_top.sv
// Memory bridge top that joins a 32-bit port to a 16-bit SRAM
`timescale 1ns/1ps

module mem_16_to_32_top
	import bus_pkg::*;
	import ram_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_rst,
	input  logic        i_enable,
	input  logic        i_rw,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic        o_ready
);

	bus_req_t    req;
	logic        req_valid;
	ram_acc_t    acc;
	logic        ram_enable;
	logic [15:0] ram_rdata;
	logic        ram_ready;

	bus_request_stage u_request (
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.i_enable    (i_enable),
		.i_rw        (i_rw),
		.i_address   (i_address),
		.i_wdata     (i_wdata),
		.o_req       (req),
		.o_req_valid (req_valid)
	);

	half_word_sequencer u_sequencer (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_req        (req),
		.i_req_valid  (req_valid),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.o_acc        (acc),
		.o_ram_enable (ram_enable),
		.i_ram_rdata  (ram_rdata),
		.i_ram_ready  (ram_ready)
	);

	sram_16 u_sram (
		.i_clock  (i_clock),
		.i_rst    (i_rst),
		.i_acc    (acc),
		.i_enable (ram_enable),
		.o_rdata  (ram_rdata),
		.o_ready  (ram_ready)
	);

endmodule

// File: sram_16.sv
// 16-bit synchronous SRAM that answers each access after a fixed wait
`timescale 1ns/1ps

`include "mem_consts.svh"

module sram_16
	import ram_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_rst,
	input  ram_acc_t    i_acc,
	input  logic        i_enable,
	output logic [15:0] o_rdata,
	output logic        o_ready
);

	localparam int CNT_W = $clog2(`RAM_WAIT + 2);

	logic [15:0]      mem [`RAM_DEPTH];
	logic [CNT_W-1:0] wait_cnt;
	logic             done_q;
	logic             expired;
	logic             do_access;

	initial begin
		for (int i = 0; i < `RAM_DEPTH; i++) begin
			mem[i] = 16'h0000;	// Blank storage in simulation
		end
	end

	assign expired   = (wait_cnt == CNT_W'(`RAM_WAIT));
	assign do_access = !i_rst && i_enable && !done_q && expired;
	assign o_ready   = done_q && i_enable;

	always_ff @(posedge i_clock) begin
		if (i_rst || !i_enable) begin
			wait_cnt <= '0;
			done_q   <= 1'b0;
		end else if (!done_q) begin
			if (expired) begin
				done_q <= 1'b1;	// Held until enable drops
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	// Read returns the old contents on a write
	always @(posedge i_clock) begin
		if (do_access) begin
			if (i_acc.rw) begin
				mem[i_acc.addr] <= i_acc.wdata;
			end
			o_rdata <= mem[i_acc.addr];
		end
	end

	// Answer comes exactly RAM_WAIT + 1 cycles after enable rises, and only under enable
	a_latency: assert property (@(posedge i_clock) disable iff (i_rst || !i_enable)
		$rose(i_enable) |-> ##(`RAM_WAIT) !o_ready ##1 o_ready);

endmodule

// File: half_word_sequencer.sv
// Half-word sequencer that runs two 16-bit RAM accesses per 32-bit request
`timescale 1ns/1ps

`include "mem_consts.svh"

module half_word_sequencer
	import bus_pkg::*;
	import ram_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_rst,
	input  bus_req_t    i_req,
	input  logic        i_req_valid,
	output logic [31:0] o_rdata,
	output logic        o_ready,
	output ram_acc_t    o_acc,
	output logic        o_ram_enable,
	input  logic [15:0] i_ram_rdata,
	input  logic        i_ram_ready
);

	seq_state_t state;
	bus_word_t  rdata_q;

	assign o_rdata = rdata_q.word;
	assign o_ready = (state == DONE) && i_req_valid;	// Falls with the request level

	always_ff @(posedge i_clock) begin
		if (i_rst || !i_req_valid) begin
			state        <= IDLE;
			o_ram_enable <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					state <= LO_ISSUE;
				end
				LO_ISSUE: begin
					o_ram_enable <= 1'b1;
					state        <= LO_WAIT;
				end
				LO_WAIT: begin
					if (i_ram_ready) begin
						o_ram_enable <= 1'b0;	// One idle cycle before the high half
						state        <= HI_ISSUE;
					end
				end
				HI_ISSUE: begin
					o_ram_enable <= 1'b1;
					state        <= HI_WAIT;
				end
				HI_WAIT: begin
					if (i_ram_ready) begin
						o_ram_enable <= 1'b0;
						state        <= DONE;
					end
				end
				default: begin
					state <= DONE;	// Hold until the requester lets go
				end
			endcase
		end
	end

	// Access word and collected read halves
	always_ff @(posedge i_clock) begin
		case (state)
			LO_ISSUE: begin
				o_acc.rw    <= i_req.rw;
				o_acc.addr  <= i_req.base;
				o_acc.wdata <= i_req.wdata.half.lo;
			end
			LO_WAIT: begin
				if (i_ram_ready) begin
					rdata_q.half.lo <= i_ram_rdata;
				end
			end
			HI_ISSUE: begin
				o_acc.rw    <= i_req.rw;
				o_acc.addr  <= {i_req.base[`RAM_ADDR_W-1:1], 1'b1};	// Base plus one
				o_acc.wdata <= i_req.wdata.half.hi;
			end
			HI_WAIT: begin
				if (i_ram_ready) begin
					rdata_q.half.hi <= i_ram_rdata;
				end
			end
			default: begin
			end
		endcase
	end

	// SRAM sees a steady access until it answers
	a_acc_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		o_ram_enable && !i_ram_ready |=> $stable(o_acc));

	// DONE is only reached through the high half
	a_ready_done: assert property (@(posedge i_clock) disable iff (i_rst)
		o_ready |-> (state == DONE) && $past(state == HI_WAIT || state == DONE));

endmodule

// File: bus_request_stage.sv
// Bus request stage that latches a 32-bit request and forms its half-word base
`timescale 1ns/1ps

`include "mem_consts.svh"

module bus_request_stage
	import bus_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_rst,
	input  logic        i_enable,
	input  logic        i_rw,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output bus_req_t    o_req,
	output logic        o_req_valid
);

	logic start;

	assign start = i_enable && !o_req_valid;	// First cycle of a new access

	always_ff @(posedge i_clock) begin
		if (i_rst || !i_enable) begin
			o_req_valid <= 1'b0;
		end else begin
			o_req_valid <= 1'b1;
		end
	end

	// Request is frozen for the whole access
	always_ff @(posedge i_clock) begin
		if (start) begin
			o_req.rw         <= i_rw;
			o_req.base       <= {i_address[`RAM_ADDR_W:2], 1'b0};	// Word to half-word
			o_req.wdata.word <= i_wdata;
		end
	end

	a_req_frozen: assert property (@(posedge i_clock) disable iff (i_rst)
		o_req_valid |=> !o_req_valid || $stable(o_req));

endmodule

// File: ram_pkg.sv
// RAM package with the half-word access and sequencer state types
package ram_pkg;

	`include "mem_consts.svh"

	typedef struct packed {
		logic                   rw;	// 1 is write
		logic [`RAM_ADDR_W-1:0] addr;
		logic [15:0]            wdata;
	} ram_acc_t;

	typedef enum logic [2:0] {
		IDLE,
		LO_ISSUE,	// Present the even half-word
		LO_WAIT,
		HI_ISSUE,	// Present the odd half-word
		HI_WAIT,
		DONE
	} seq_state_t;

endpackage

// File: bus_pkg.sv
// Bus package with the 32-bit request and data word types
package bus_pkg;

	`include "mem_consts.svh"

	typedef struct packed {
		logic [15:0] hi;	// Odd half-word address
		logic [15:0] lo;	// Even half-word address
	} half_pair_t;

	// One data word, seen whole or as two half-words
	typedef union packed {
		logic [31:0] word;
		half_pair_t  half;
	} bus_word_t;

	typedef struct packed {
		logic                   rw;	// 1 is write
		logic [`RAM_ADDR_W-1:0] base;	// Even half-word address
		bus_word_t              wdata;
	} bus_req_t;

endpackage

// File: mem_consts.svh
// Memory bridge constants for the 16-bit SRAM side
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Half-word address width of the SRAM
`define RAM_ADDR_W 18

// Half-words held by the storage array
`define RAM_DEPTH (1 << `RAM_ADDR_W)

// Extra cycles the SRAM waits before it answers an access
// Zero gives a one-cycle answer
`define RAM_WAIT 2

`endif
